// ==== hdl/aluPkg.sv ====
package aluPkg;

    // ==================================================
    // Widths and constants
    // ==================================================
    localparam int dataWidth  = 32;
    localparam int shamtWidth = 5;
    localparam int sraiBit    = 10;    // imm12 bit that turns SRLI into SRAI

    localparam logic [dataWidth-1:0] pcStep = 32'd4;    // Link address increment

    // Execute controller states
    localparam logic [1:0] stIdle   = 2'd0;
    localparam logic [1:0] stRun    = 2'd1;
    localparam logic [1:0] stFinish = 2'd2;

    // ==================================================
    // Main decoder classes and ALU operations
    // ==================================================
    typedef enum logic [3:0] {
        J       = 4'd0,
        U_LUI   = 4'd1,
        U_AUIPC = 4'd2,
        S       = 4'd3,
        I_SYS   = 4'd4,
        I_LOAD  = 4'd5,
        I_JUMP  = 4'd6,
        I_FENCE = 4'd7,
        B       = 4'd8,
        I_ARITH = 4'd9,
        R       = 4'd10
    } aluOpT;

    typedef enum logic [4:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        AND   = 5'd2,
        OR    = 5'd3,
        XOR   = 5'd4,
        SLL   = 5'd5,
        SRL   = 5'd6,
        SRA   = 5'd7,
        PASSB = 5'd8,
        ADD4A = 5'd9,
        EQ    = 5'd10,
        NEQ   = 5'd11,
        SLT   = 5'd12,
        SGTE  = 5'd13,
        SLTU  = 5'd14,
        SGTEU = 5'd15
    } aluCtrlT;

    // ==================================================
    // Instruction layouts
    // ==================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    // Same word, two views
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

endpackage

// ==== hdl/shiftIf.sv ====
`timescale 1ns/100ps

interface shiftIf;
    import aluPkg::*;

    logic                 load;     // Take seed
    logic                 step;     // Move one place
    aluCtrlT              mode;     // SLL, SRL or SRA
    logic [dataWidth-1:0] seed;
    logic [dataWidth-1:0] value;    // Current register contents

    modport controller (
        output load,
        output step,
        output mode,
        output seed,
        input  value
    );

    modport shifter (
        input  load,
        input  step,
        input  mode,
        input  seed,
        output value
    );

endinterface

// ==== hdl/aluDecode.sv ====
`timescale 1ns/100ps

module aluDecode (
    input  aluPkg::aluOpT   aluOp,
    input  aluPkg::instrU   instr,
    output aluPkg::aluCtrlT op,
    output logic            illegal
);
    import aluPkg::*;

    always_comb begin
        op      = ADD;      // Safe fallback for bad encodings
        illegal = 1'b0;
        case (aluOp)
            // U/J formats
            J       : op = ADD4A;
            U_LUI   : op = PASSB;
            U_AUIPC : op = ADD;
            // Address calculations all use the adder
            S, I_SYS, I_LOAD, I_JUMP, I_FENCE : op = ADD;
            B : begin
                case (instr.r.funct3)
                    3'b000  : op = EQ;
                    3'b001  : op = NEQ;
                    3'b100  : op = SLT;
                    3'b101  : op = SGTE;
                    3'b110  : op = SLTU;
                    3'b111  : op = SGTEU;
                    default : illegal = 1'b1;
                endcase
            end
            I_ARITH : begin
                case (instr.i.funct3)
                    3'b000  : op = ADD;
                    3'b010  : op = SLT;
                    3'b011  : op = SLTU;
                    3'b100  : op = XOR;
                    3'b110  : op = OR;
                    3'b111  : op = AND;
                    3'b001  : op = SLL;
                    3'b101  : op = instr.i.imm12[sraiBit] ? SRA : SRL;
                    default : illegal = 1'b1;
                endcase
            end
            R : begin
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000_000 : op = ADD;
                    10'b0100000_000 : op = SUB;
                    10'b0000000_001 : op = SLL;
                    10'b0000000_010 : op = SLT;
                    10'b0000000_011 : op = SLTU;
                    10'b0000000_100 : op = XOR;
                    10'b0000000_101 : op = SRL;
                    10'b0100000_101 : op = SRA;
                    10'b0000000_110 : op = OR;
                    10'b0000000_111 : op = AND;
                    default         : illegal = 1'b1;
                endcase
            end
            default : illegal = 1'b1;   // Unused class codes
        endcase
    end

endmodule

// ==== hdl/aluCore.sv ====
`timescale 1ns/100ps

module aluCore (
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    input  aluPkg::aluCtrlT              op,
    output logic [aluPkg::dataWidth-1:0] result
);
    import aluPkg::*;

    logic                 subEn;
    logic [dataWidth-1:0] addB;
    logic [dataWidth-1:0] finalB;   // Inverted for subtract
    logic [dataWidth-1:0] p;
    logic [dataWidth-1:0] g;
    logic [dataWidth:0]   c;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] xorAB;
    logic                 isEq;
    logic                 lessS;
    logic                 cout;

    // ==================================================
    // Adder setup
    // ==================================================
    always_comb begin
        subEn = 1'b0;
        addB  = b;
        case (op)
            SUB, SLT, SGTE, SLTU, SGTEU : subEn = 1'b1;
            ADD4A                       : addB  = pcStep;
            default                     : subEn = 1'b0;
        endcase
    end

    assign finalB = subEn ? ~addB : addB;
    assign c[0]   = subEn;      // +1 completes two's complement
    assign cout   = c[dataWidth];

    // Lookahead inside 4-bit groups, group carries chained
    genvar grp;
    generate
        for (grp = 0; grp < dataWidth / 4; grp++) begin : gCla
            localparam int base = grp * 4;
            assign p[base+3:base] = a[base+3:base] ^ finalB[base+3:base];
            assign g[base+3:base] = a[base+3:base] & finalB[base+3:base];
            assign c[base+1] = g[base] | (p[base] & c[base]);
            assign c[base+2] = g[base+1] | (p[base+1] & g[base])
                             | (p[base+1] & p[base] & c[base]);
            assign c[base+3] = g[base+2] | (p[base+2] & g[base+1])
                             | (p[base+2] & p[base+1] & g[base])
                             | (p[base+2] & p[base+1] & p[base] & c[base]);
            assign c[base+4] = g[base+3] | (p[base+3] & g[base+2])
                             | (p[base+3] & p[base+2] & g[base+1])
                             | (p[base+3] & p[base+2] & p[base+1] & g[base])
                             | (p[base+3] & p[base+2] & p[base+1] & p[base] & c[base]);
            assign sum[base+3:base] = p[base+3:base] ^ c[base+3:base];
        end
    endgenerate

    // ==================================================
    // Compares and result select
    // ==================================================
    assign xorAB = a ^ b;
    assign isEq  = ~|xorAB;

    always_comb begin
        case ({a[dataWidth-1], b[dataWidth-1]})
            2'b01   : lessS = 1'b0;     // a positive, b negative
            2'b10   : lessS = 1'b1;
            default : lessS = sum[dataWidth-1];
        endcase
    end

    always_comb begin
        case (op)
            ADD, SUB, ADD4A : result = sum;
            AND     : result = a & b;
            OR      : result = a | b;
            XOR     : result = xorAB;
            PASSB   : result = b;
            EQ      : result = {{(dataWidth-1){1'b0}}, isEq};
            NEQ     : result = {{(dataWidth-1){1'b0}}, ~isEq};
            SLT     : result = {{(dataWidth-1){1'b0}}, lessS};
            SGTE    : result = {{(dataWidth-1){1'b0}}, ~lessS};
            SLTU    : result = {{(dataWidth-1){1'b0}}, ~cout};  // Borrow means a < b
            SGTEU   : result = {{(dataWidth-1){1'b0}}, cout};
            default : result = '0;      // Shifts go through the serial shifter
        endcase
    end

endmodule

// ==== hdl/shiftCounter.sv ====
`timescale 1ns/100ps

module shiftCounter (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          load,
    input  logic [aluPkg::shamtWidth-1:0] count,
    output logic                          expired
);
    import aluPkg::*;

    logic [shamtWidth-1:0] cnt;     // Steps still to go

    assign expired = (cnt == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= count;
        end else if (!expired) begin
            cnt <= cnt - 1'b1;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    // Once at zero it stays there until reloaded
    assert property (@(posedge clk) disable iff (!rstN)
        !load && expired |=> expired)
        else $error("shiftCounter wrapped below zero");

endmodule

// ==== hdl/serialShifter.sv ====
`timescale 1ns/100ps

module serialShifter (
    input logic    clk,
    input logic    rstN,
    shiftIf.shifter bus
);
    import aluPkg::*;

    logic [dataWidth-1:0] shReg;

    assign bus.value = shReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shReg <= '0;
        end else if (bus.load) begin
            shReg <= bus.seed;
        end else if (bus.step) begin
            case (bus.mode)
                SLL     : shReg <= {shReg[dataWidth-2:0], 1'b0};
                SRL     : shReg <= {1'b0, shReg[dataWidth-1:1]};
                SRA     : shReg <= {shReg[dataWidth-1], shReg[dataWidth-1:1]};  // Sign fill
                default : shReg <= shReg;
            endcase
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    // Controller must never load mid-shift
    assert property (@(posedge clk) disable iff (!rstN)
        !(bus.load && bus.step))
        else $error("serialShifter load and step together");

    // Stepping only makes sense for a shift op
    assert property (@(posedge clk) disable iff (!rstN)
        bus.step |-> bus.mode inside {SLL, SRL, SRA})
        else $error("serialShifter stepped with non-shift mode");

endmodule

// ==== hdl/execControl.sv ====
`timescale 1ns/100ps

module execControl (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,
    input  aluPkg::aluCtrlT               decOp,
    input  logic                          decIllegal,
    input  logic [aluPkg::dataWidth-1:0]  a,
    input  logic [aluPkg::dataWidth-1:0]  b,
    input  logic [aluPkg::dataWidth-1:0]  coreResult,
    input  logic                          expired,
    output logic [aluPkg::dataWidth-1:0]  coreA,
    output logic [aluPkg::dataWidth-1:0]  coreB,
    output aluPkg::aluCtrlT               coreOp,
    output logic                          cntLoad,
    output logic [aluPkg::shamtWidth-1:0] cntCount,
    output logic [aluPkg::dataWidth-1:0]  result,
    output logic                          zero,
    output logic                          illegal,
    output logic                          done,
    output logic                          busy,
    shiftIf.controller                    shf
);
    import aluPkg::*;

    logic [1:0]           state;
    logic                 accept;       // Start taken this edge
    logic                 decShift;
    logic                 shiftQ;
    logic                 illegalPend;
    logic [dataWidth-1:0] finalRes;

    assign accept   = start && (state != stRun);
    assign decShift = (decOp == SLL) || (decOp == SRL) || (decOp == SRA);

    // Counter and shifter are loaded at the start edge
    assign cntLoad  = accept;
    assign cntCount = decShift ? b[shamtWidth-1:0] : '0;
    assign shf.load = accept;
    assign shf.seed = a;
    assign shf.mode = coreOp;
    assign shf.step = (state == stRun) && !expired;

    assign finalRes = shiftQ ? shf.value : coreResult;
    assign busy     = (state == stRun);
    assign done     = (state == stFinish);

    // ==================================================
    // Request capture
    // ==================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            coreA       <= a;
            coreB       <= b;
            coreOp      <= decOp;
            illegalPend <= decIllegal;
        end
    end

    // ==================================================
    // FSM and result registers
    // ==================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= stIdle;
            shiftQ  <= 1'b0;
            result  <= '0;
            zero    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            case (state)
                stRun : begin
                    if (expired) begin
                        state   <= stFinish;
                        result  <= finalRes;
                        zero    <= ~|finalRes;
                        illegal <= illegalPend;
                    end
                end
                default : begin     // Idle or finish
                    if (accept) begin
                        state  <= stRun;
                        shiftQ <= decShift;
                    end else begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("done wider than one cycle");

    // done only follows a running request
    assert property (@(posedge clk) disable iff (!rstN) $rose(done) |-> $past(busy))
        else $error("done raised without a request");

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/100ps

module execUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         start,
    input  aluPkg::aluOpT                aluOp,
    input  aluPkg::instrU                instr,
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         zero,
    output logic                         illegal,
    output logic                         done,
    output logic                         busy
);
    import aluPkg::*;

    aluCtrlT               decOp;
    logic                  decIllegal;
    logic [dataWidth-1:0]  coreA;
    logic [dataWidth-1:0]  coreB;
    aluCtrlT               coreOp;
    logic [dataWidth-1:0]  coreResult;
    logic                  cntLoad;
    logic [shamtWidth-1:0] cntCount;
    logic                  expired;

    shiftIf shfBus ();      // Controller to shifter

    aluDecode i_aluDecode (
        .aluOp   (aluOp),
        .instr   (instr),
        .op      (decOp),
        .illegal (decIllegal)
    );

    execControl i_execControl (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .decOp      (decOp),
        .decIllegal (decIllegal),
        .a          (a),
        .b          (b),
        .coreResult (coreResult),
        .expired    (expired),
        .coreA      (coreA),
        .coreB      (coreB),
        .coreOp     (coreOp),
        .cntLoad    (cntLoad),
        .cntCount   (cntCount),
        .result     (result),
        .zero       (zero),
        .illegal    (illegal),
        .done       (done),
        .busy       (busy),
        .shf        (shfBus.controller)
    );

    aluCore i_aluCore (
        .a      (coreA),
        .b      (coreB),
        .op     (coreOp),
        .result (coreResult)
    );

    shiftCounter i_shiftCounter (
        .clk     (clk),
        .rstN    (rstN),
        .load    (cntLoad),
        .count   (cntCount),
        .expired (expired)
    );

    serialShifter i_serialShifter (
        .clk  (clk),
        .rstN (rstN),
        .bus  (shfBus.shifter)
    );

endmodule

// ==== tb/execModel.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Reference behaviour of the execute unit, written from the RV32I rules

// ==================================================
// Operation and illegal flag from class and word
// ==================================================
function automatic void predictDecode(input aluOpT cls, input instrU word,
                                      output aluCtrlT op, output logic bad);
    aluCtrlT brTable [8];
    aluCtrlT arTable [8];
    logic [6:0] f7;
    logic [2:0] f3;
    brTable = '{EQ, NEQ, ADD, ADD, SLT, SGTE, SLTU, SGTEU};
    arTable = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    f7  = word.r.funct7;
    f3  = word.r.funct3;
    op  = ADD;
    bad = 1'b0;
    if (cls == J) begin
        op = ADD4A;                 // Link address
    end else if (cls == U_LUI) begin
        op = PASSB;
    end else if (cls == B) begin
        op  = brTable[f3];
        bad = (f3 == 3'b010) || (f3 == 3'b011);
    end else if (cls == I_ARITH) begin
        op = arTable[word.i.funct3];
        if (word.i.funct3 == 3'b101 && word.i.imm12[10]) begin
            op = SRA;               // SRAI
        end
    end else if (cls == R) begin
        if (f7 == 7'b0000000) begin
            op = arTable[f3];
        end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
            op = SUB;
        end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
            op = SRA;
        end else begin
            bad = 1'b1;
        end
    end else if (cls > R) begin
        bad = 1'b1;
    end
endfunction

// ==================================================
// Result and cycles to done
// ==================================================
function automatic logic [31:0] predictResult(input aluCtrlT op, input logic [31:0] x,
                                              input logic [31:0] y);
    logic [4:0] sh;
    sh = y[4:0];
    case (op)
        SUB     : return x - y;
        AND     : return x & y;
        OR      : return x | y;
        XOR     : return x ^ y;
        SLL     : return x << sh;
        SRL     : return x >> sh;
        SRA     : return $signed(x) >>> sh;
        PASSB   : return y;
        ADD4A   : return x + 32'd4;
        EQ      : return {31'b0, x == y};
        NEQ     : return {31'b0, x != y};
        SLT     : return {31'b0, $signed(x) < $signed(y)};
        SGTE    : return {31'b0, $signed(x) >= $signed(y)};
        SLTU    : return {31'b0, x < y};
        SGTEU   : return {31'b0, x >= y};
        default : return x + y;
    endcase
endfunction

function automatic int predictLatency(input aluCtrlT op, input logic [31:0] y);
    if (op == SLL || op == SRL || op == SRA) begin
        return int'(y[4:0]) + 1;    // One step per bit, then the finish edge
    end
    return 1;
endfunction

`endif

// ==== tb/execUnitTb.sv ====
`timescale 1ns/100ps

module execUnitTb;
    import aluPkg::*;

    `include "execModel.svh"

    localparam int numRequests   = 82;
    localparam int timeoutCycles = numRequests * 34 + 200;

    logic        clk;
    logic        rstN;
    logic        start;
    aluOpT       aluOp;
    instrU       instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        zero;
    logic        illegal;
    logic        done;
    logic        busy;

    // Expected values of the request in flight
    logic [31:0] expResult;
    logic        expZero;
    logic        expIllegal;
    int          expLatency;
    logic        pending = 1'b0;

    int          cycleCount = 0;
    int          startCycle = 0;
    int          requests   = 0;
    int          checkFails = 0;
    int          flowFails  = 0;
    logic [31:0] rngState;

    execUnit i_execUnit (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .aluOp   (aluOp),
        .instr   (instr),
        .a       (a),
        .b       (b),
        .result  (result),
        .zero    (zero),
        .illegal (illegal),
        .done    (done),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle count for latency and timeout
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= timeoutCycles);
        $display("Timeout after %0d cycles, the run did not finish", cycleCount);
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // Checks on every completed request
    // ==================================================
    assert property (@(negedge clk) disable iff (!rstN) done |-> (result == expResult))
        else begin
            checkFails++;
            $display("MISMATCH t=%0t result got %h expected %h", $time, result, expResult);
        end

    assert property (@(negedge clk) disable iff (!rstN) done |-> (zero == expZero))
        else begin
            checkFails++;
            $display("MISMATCH t=%0t zero got %b expected %b", $time, zero, expZero);
        end

    assert property (@(negedge clk) disable iff (!rstN) done |-> (illegal == expIllegal))
        else begin
            checkFails++;
            $display("MISMATCH t=%0t illegal got %b expected %b", $time, illegal, expIllegal);
        end

    assert property (@(negedge clk) disable iff (!rstN)
        done |-> ((cycleCount - startCycle) == expLatency))
        else begin
            checkFails++;
            $display("MISMATCH t=%0t latency got %0d expected %0d", $time,
                     cycleCount - startCycle, expLatency);
        end

    // busy spans the start edge up to the edge that raises done
    assert property (@(negedge clk) disable iff (!rstN)
        busy == (pending && (cycleCount - startCycle) < expLatency))
        else begin
            checkFails++;
            $display("MISMATCH t=%0t busy got %b expected %b", $time, busy,
                     pending && (cycleCount - startCycle) < expLatency);
        end

    // An ignored start must not produce a second done
    assert property (@(negedge clk) disable iff (!rstN) done |-> pending)
        else begin
            checkFails++;
            $display("done raised at %0t with no request outstanding", $time);
        end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [31:0] nextRandom();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    function automatic instrU rWord(input logic [6:0] f7, input logic [2:0] f3);
        instrU w;
        w          = '0;
        w.r.funct7 = f7;
        w.r.rs2    = 5'd7;
        w.r.rs1    = 5'd6;
        w.r.funct3 = f3;
        w.r.rd     = 5'd5;
        w.r.opcode = 7'b0110011;
        return w;
    endfunction

    function automatic instrU bWord(input logic [2:0] f3);
        instrU w;
        w          = rWord(7'b0000000, f3);
        w.r.opcode = 7'b1100011;    // Branch
        return w;
    endfunction

    function automatic instrU iWord(input logic [11:0] imm, input logic [2:0] f3);
        instrU w;
        w          = '0;
        w.i.imm12  = imm;
        w.i.rs1    = 5'd9;
        w.i.funct3 = f3;
        w.i.rd     = 5'd8;
        w.i.opcode = 7'b0010011;
        return w;
    endfunction

    // Called on a rising edge, returns on a rising edge
    task automatic issue(input aluOpT cls, input instrU word, input logic [31:0] opA,
                         input logic [31:0] opB, input logic intrude);
        aluCtrlT op;
        logic    bad;
        int      waited;
        predictDecode(cls, word, op, bad);
        expResult  = predictResult(op, opA, opB);
        expZero    = (expResult == '0);
        expIllegal = bad;
        expLatency = predictLatency(op, opB);
        requests++;
        start <= 1'b1;
        aluOp <= cls;
        instr <= word;
        a     <= opA;
        b     <= opB;
        @(posedge clk);
        start      <= 1'b0;
        startCycle = cycleCount + 1;    // Count as it reads after the start edge
        pending    = 1'b1;
        if (intrude) begin
            repeat (4) @(posedge clk);
            start <= 1'b1;          // Unit is mid-shift here
            aluOp <= R;
            instr <= rWord(7'b0000000, 3'b000);
            a     <= ~opA;
            b     <= 32'd3;
            @(posedge clk);
            start <= 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (!done && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            flowFails++;
            $display("Request %0d never raised done", requests);
        end
        @(posedge clk);
        pending = 1'b0;
    endtask

    task automatic finishTest(input string name, input int failsBefore);
        int newFails;
        newFails = checkFails + flowFails - failsBefore;
        if (newFails == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, newFails);
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic runRType();
        logic [9:0]  codes [7];
        logic [31:0] x;
        logic [31:0] y;
        int          k;
        // ADD SUB AND OR XOR SLT SLTU as {funct7, funct3}
        codes = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111, 10'b0000000_110,
                  10'b0000000_100, 10'b0000000_010, 10'b0000000_011};
        for (k = 0; k < 7; k++) begin
            x = nextRandom();
            y = nextRandom();
            issue(R, rWord(codes[k][9:3], codes[k][2:0]), x, y, 1'b0);
            issue(R, rWord(codes[k][9:3], codes[k][2:0]), 32'h8000_0000, 32'h7fff_ffff, 1'b0);
            issue(R, rWord(codes[k][9:3], codes[k][2:0]), 32'h7fff_ffff, 32'h8000_0000, 1'b0);
            issue(R, rWord(codes[k][9:3], codes[k][2:0]), x, x, 1'b0);    // SUB gives zero
        end
    endtask

    task automatic runITypeAndBranch();
        logic [2:0]  arF3 [6];
        logic [2:0]  brF3 [6];
        logic [31:0] x;
        logic [11:0] imm;
        int          k;
        arF3 = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (k = 0; k < 6; k++) begin
            x   = nextRandom();
            imm = x[23:12];
            issue(I_ARITH, iWord(imm, arF3[k]), nextRandom(), {{20{imm[11]}}, imm}, 1'b0);
        end
        // Same shift amount, only imm12 bit 10 differs
        issue(I_ARITH, iWord(12'h004, 3'b101), 32'hf0f0_1234, 32'h0000_0004, 1'b0);
        issue(I_ARITH, iWord(12'h404, 3'b101), 32'hf0f0_1234, 32'h0000_0404, 1'b0);
        for (k = 0; k < 6; k++) begin
            x = nextRandom();
            issue(B, bWord(brF3[k]), x, x, 1'b0);
            issue(B, bWord(brF3[k]), 32'hffff_fff0, 32'h0000_0010, 1'b0);
            issue(B, bWord(brF3[k]), 32'h0000_0010, 32'hffff_fff0, 1'b0);
        end
    endtask

    task automatic runShifts();
        logic [9:0]  codes [3];
        logic [31:0] amounts [5];
        logic [31:0] x;
        int          k;
        int          j;
        codes = '{10'b0000000_001, 10'b0000000_101, 10'b0100000_101};
        for (k = 0; k < 3; k++) begin
            amounts = '{32'd0, 32'd1, 32'd31, nextRandom(), nextRandom()};
            for (j = 0; j < 5; j++) begin
                x     = nextRandom();
                x[31] = j[0];       // Both signs for SRA
                issue(R, rWord(codes[k][9:3], codes[k][2:0]), x, amounts[j], 1'b0);
            end
        end
    endtask

    task automatic runFormats();
        logic [31:0] x;
        logic [31:0] y;
        x = nextRandom();
        y = nextRandom();
        issue(U_LUI, iWord(12'h0a5, 3'b000), x, y, 1'b0);
        issue(J, iWord(12'h000, 3'b000), x, y, 1'b0);
        issue(J, iWord(12'h000, 3'b000), 32'hffff_fffc, y, 1'b0);  // Wraps to zero
        issue(U_AUIPC, iWord(12'h000, 3'b000), x, y, 1'b0);
        issue(S, iWord(12'h010, 3'b010), x, 32'h0000_0010, 1'b0);
        issue(I_LOAD, iWord(12'hffc, 3'b010), x, 32'hffff_fffc, 1'b0);
        issue(I_SYS, iWord(12'h000, 3'b000), y, x, 1'b0);
        issue(I_FENCE, iWord(12'h000, 3'b000), x, ~x + 1'b1, 1'b0);
    endtask

    task automatic runIllegalAndBusy();
        issue(R, rWord(7'b0000001, 3'b000), nextRandom(), nextRandom(), 1'b0);
        issue(R, rWord(7'b0100000, 3'b001), nextRandom(), nextRandom(), 1'b0);
        issue(B, bWord(3'b010), nextRandom(), nextRandom(), 1'b0);
        issue(B, bWord(3'b011), nextRandom(), nextRandom(), 1'b0);
        // Long SLL with a second start while busy
        issue(R, rWord(7'b0000000, 3'b001), nextRandom(), 32'd20, 1'b1);
        repeat (40) @(posedge clk);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int mark;
        rstN     = 1'b0;
        start    = 1'b0;
        aluOp    = R;
        instr    = '0;
        a        = '0;
        b        = '0;
        rngState = 32'd15215;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        mark = checkFails + flowFails;
        runRType();
        finishTest("R-type arithmetic and compares", mark);
        mark = checkFails + flowFails;
        runITypeAndBranch();
        finishTest("I-type arithmetic and branch compares", mark);
        mark = checkFails + flowFails;
        runShifts();
        finishTest("Serial shifts", mark);
        mark = checkFails + flowFails;
        runFormats();
        finishTest("U/J and memory classes", mark);
        mark = checkFails + flowFails;
        runIllegalAndBusy();
        finishTest("Illegal encodings and start while busy", mark);

        $display("Requests %0d, check failures %0d, flow failures %0d",
                 requests, checkFails, flowFails);
        if (checkFails == 0 && flowFails == 0 && requests == numRequests) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tb
hdl/aluPkg.sv
hdl/shiftIf.sv
hdl/aluDecode.sv
hdl/aluCore.sv
hdl/shiftCounter.sv
hdl/serialShifter.sv
hdl/execControl.sv
hdl/execUnit.sv
tb/execUnitTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert --timing -Mdir obj_dir
LINT     = --lint-only --assert --timing
TOP      = execUnitTb
FILELIST = build.f
LOG      = sim.log
FAIL_MSG = Simulation failed
PASS_MSG = Simulation completed successfully
BIN      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run FAILED, no pass line"; exit 1; fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
